//--- files.f
rtl/ws281x_pkg.sv
rtl/ws281x_ram.sv
rtl/ws281x_ctrl.sv
rtl/ws281x_bit.sv
rtl/ws281x_top.sv
test/ws281x_props.sv
test/ws281x_tb.sv

//--- rtl/ws281x_bit.sv
// ####################
// one-wire bit encoder; needs tim_sum >= 8, t0h >= 1, t1h < tim_sum - 1.
// settings must be held stable while a frame is sent.
// ####################

module ws281x_bit (
    input  logic             clk_in,
    input  logic             rst_n_in,

    input  logic             bit_rdy,
    input  logic             bit_data,

    input  ws281x_pkg::tim_t t0h,
    input  ws281x_pkg::tim_t t1h,
    input  ws281x_pkg::tim_t tim_sum,

    output logic             bit_done,
    output logic             dout
);

    import ws281x_pkg::*;

    bit_state_t state;
    tim_t       cnt;
    logic       bit_val;
    tim_t       high_len;

    assign high_len = bit_val ? t1h : t0h;

    // cnt is 0 in the cycle where dout rises. bit_done is registered from
    // cnt == tim_sum - 3, so it is seen at tim_sum - 2, and the next bit_rdy
    // lands in the last cycle of the period.
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state    <= bit_idle;
            cnt      <= '0;
            bit_val  <= 1'b0;
            dout     <= 1'b0;
            bit_done <= 1'b0;
        end else begin
            bit_done <= (state != bit_idle) && (cnt == tim_sum - tim_t'(3));
            if (bit_rdy) begin
                state   <= bit_high;
                cnt     <= '0;
                bit_val <= bit_data;
                dout    <= 1'b1;
            end else begin
                case (state)
                    bit_high: begin
                        cnt <= cnt + tim_t'(1);
                        if (cnt == high_len - tim_t'(1)) begin
                            dout  <= 1'b0;
                            state <= bit_low;
                        end
                    end
                    bit_low: begin
                        cnt <= cnt + tim_t'(1);
                        // no follow-up bit, the line rests low.
                        if (cnt == tim_sum - tim_t'(1)) begin
                            state <= bit_idle;
                        end
                    end
                    default: begin
                        state <= bit_idle;
                        dout  <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/ws281x_ctrl.sv
// ####################
// frame sequencer; start is ignored unless idle, and tim_sum must stay
// stable during a frame. the walk always begins at address 0.
// ####################

module ws281x_ctrl (
    input  logic              clk_in,
    input  logic              rst_n_in,

    input  logic              start,
    input  logic              bit_done,
    input  ws281x_pkg::word_t rd_data,
    input  ws281x_pkg::tim_t  tim_sum,

    output logic              bit_rdy,
    output logic              bit_data,

    output logic              rd_en,
    output ws281x_pkg::addr_t rd_addr
);

    import ws281x_pkg::*;

    ctrl_state_t state;

    logic        first_bit;
    logic [4:0]  bit_idx;
    logic        rd_done;
    color_t      shift;
    gap_t        gap_cnt;

    logic        bit_next;
    logic        last_bit;
    logic        chain_end;
    logic        gap_done;
    logic        issue;

    // the first bit of a frame starts on its own, all others wait for the
    // encoder to signal that the current period is nearly over.
    assign bit_next  = first_bit || bit_done;
    assign issue     = (state == ctrl_send_bit) && bit_next;
    assign last_bit  = (bit_idx == 5'(COLOR_BITS - 1));
    assign chain_end = (rd_addr == '0);
    assign gap_done  = (gap_cnt == gap_t'({tim_sum, 1'b0}) - gap_t'(6));

    assign rd_en = (state == ctrl_read_ram) && !rd_done;

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state <= ctrl_idle;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (start) begin
                        state <= ctrl_read_ram;
                    end
                end
                ctrl_read_ram: begin
                    if (rd_done) begin
                        state <= ctrl_send_bit;
                    end
                end
                ctrl_send_bit: begin
                    if (bit_next && last_bit) begin
                        state <= chain_end ? ctrl_sync_bit : ctrl_read_ram;
                    end
                end
                ctrl_sync_bit: begin
                    if (gap_done) begin
                        state <= ctrl_idle;
                    end
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            first_bit <= 1'b0;
            bit_idx   <= '0;
            rd_done   <= 1'b0;
            gap_cnt   <= '0;
            bit_rdy   <= 1'b0;
            bit_data  <= 1'b0;
            rd_addr   <= '0;
        end else begin
            // armed in idle, cleared once the first bit has gone out.
            first_bit <= (state == ctrl_idle) || (first_bit && (state != ctrl_send_bit));
            rd_done   <= rd_en;
            bit_rdy   <= issue;
            bit_idx   <= (state == ctrl_send_bit) ? bit_idx + 5'(bit_next) : '0;
            gap_cnt   <= (state == ctrl_sync_bit) ? gap_cnt + gap_t'(1) : '0;
            if (issue) begin
                bit_data <= shift[COLOR_BITS-1];
            end
            // a link of 0 marks the last record and also restarts the next frame at 0.
            if (rd_done) begin
                rd_addr <= rd_data[NEXT_LSB +: $bits(addr_t)];
            end
        end
    end

    // colour shift register, loaded from the fetched record.
    always_ff @(posedge clk_in) begin
        if (rd_done) begin
            shift <= rd_data[COLOR_BITS-1:0];
        end else if (issue) begin
            shift <= {shift[COLOR_BITS-2:0], 1'b0};
        end
    end

endmodule

//--- rtl/ws281x_pkg.sv
// ####################
// shared widths, record layout and FSM encodings for the WS281x driver.
// the record link field sets the frame memory depth to 64.
// ####################

package ws281x_pkg;

    // frame memory geometry and record layout.
    localparam int RAM_DEPTH  = 64;
    localparam int NEXT_LSB   = 24;
    localparam int COLOR_BITS = 24;

    // a frame memory address, also used as the next-record link.
    typedef logic [5:0] addr_t;

    // one frame memory record: link in bits 29..24, colour in bits 23..0.
    typedef logic [31:0] word_t;

    // one pixel colour, most significant bit goes out on the wire first.
    typedef logic [23:0] color_t;

    // timing settings in clock cycles.
    typedef logic [7:0] tim_t;

    // latch gap counter, wide enough for twice the bit period.
    typedef logic [8:0] gap_t;

    typedef enum logic [1:0] {
        ctrl_idle     = 2'b00,
        ctrl_read_ram = 2'b01,
        ctrl_send_bit = 2'b10,
        ctrl_sync_bit = 2'b11
    } ctrl_state_t;

    typedef enum logic [1:0] {
        bit_idle = 2'b00,
        bit_high = 2'b01,
        bit_low  = 2'b10
    } bit_state_t;

endpackage

//--- rtl/ws281x_ram.sv
// ####################
// 64 x 32 frame memory; array contents are undefined after reset.
// read data appears one cycle after rd_en and holds until the next read.
// ####################

module ws281x_ram (
    input  logic              clk_in,
    input  logic              rst_n_in,

    // host write port.
    input  logic              wr_en,
    input  ws281x_pkg::addr_t wr_addr,
    input  ws281x_pkg::word_t wr_data,

    // sequencer read port.
    input  logic              rd_en,
    input  ws281x_pkg::addr_t rd_addr,
    output ws281x_pkg::word_t rd_data
);

    import ws281x_pkg::*;

    word_t mem [RAM_DEPTH];

    // the host stores a record on the edge where wr_en is high.
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // the read register keeps the last word fetched, so the sequencer
    // can sample it any time before the next read.
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- rtl/ws281x_top.sv
// ####################
// WS281x strip driver; do not pulse start while a frame is running.
// ####################

module ws281x_top (
    input  logic              clk_in,
    input  logic              rst_n_in,

    // host access to the frame memory.
    input  logic              wr_en,
    input  ws281x_pkg::addr_t wr_addr,
    input  ws281x_pkg::word_t wr_data,

    input  logic              start,

    // run-time timing settings in clock cycles.
    input  ws281x_pkg::tim_t  t0h,
    input  ws281x_pkg::tim_t  t1h,
    input  ws281x_pkg::tim_t  tim_sum,

    output logic              dout
);

    import ws281x_pkg::*;

    logic  rd_en;
    addr_t rd_addr;
    word_t rd_data;

    logic  bit_rdy;
    logic  bit_data;
    logic  bit_done;

    ws281x_ram ws281x_ram_inst (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    ws281x_ctrl ws281x_ctrl_inst (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .start    (start),
        .bit_done (bit_done),
        .rd_data  (rd_data),
        .tim_sum  (tim_sum),
        .bit_rdy  (bit_rdy),
        .bit_data (bit_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr)
    );

    ws281x_bit ws281x_bit_inst (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .bit_rdy  (bit_rdy),
        .bit_data (bit_data),
        .t0h      (t0h),
        .t1h      (t1h),
        .tim_sum  (tim_sum),
        .bit_done (bit_done),
        .dout     (dout)
    );

endmodule

//--- test/ws281x_props.sv
// ####################
// protocol checks on the sequencer strobes; active only out of reset.
// ####################

module ws281x_props (
    input logic                    clk_in,
    input logic                    rst_n_in,
    input logic                    rd_en,
    input logic                    bit_rdy,
    input ws281x_pkg::ctrl_state_t state
);

    timeunit 1ns;
    timeprecision 100ps;

    import ws281x_pkg::*;

    // failures seen so far, read by the testbench at the end of the run.
    int unsigned assert_errors = 0;

    // a memory read is a single-cycle strobe.
    rd_en_single: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        rd_en |=> !rd_en)
        else begin
            assert_errors++;
            $error("rd_en stayed high for two cycles");
        end

    // the encoder gets one request per bit period.
    bit_rdy_single: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        bit_rdy |=> !bit_rdy)
        else begin
            assert_errors++;
            $error("bit_rdy was high in two consecutive cycles");
        end

    bit_rdy_not_idle: assert property (@(posedge clk_in) disable iff (!rst_n_in)
        !(bit_rdy && (state == ctrl_idle)))
        else begin
            assert_errors++;
            $error("bit_rdy was issued while the sequencer was idle");
        end

endmodule

//--- test/ws281x_tb.sv
// ####################
// directed testbench; dout is sampled on falling clock edges.
// timing settings are only changed while the driver is idle.
// ####################

module ws281x_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ws281x_pkg::*;

    localparam int WAIT_LIMIT = 1000;

    logic        clk_in;
    logic        rst_n_in;
    logic        wr_en;
    addr_t       wr_addr;
    word_t       wr_data;
    logic        start;
    tim_t        t0h;
    tim_t        t1h;
    tim_t        tim_sum;
    logic        dout;

    int unsigned value_errors;
    int unsigned wait_errors;
    logic [31:0] lfsr;

    // what the line decoder saw in the last frame.
    int unsigned widths[$];
    int unsigned periods[$];
    int unsigned first_rise;
    logic        late_high;

    color_t      exp_colors[$];

    ws281x_top ws281x_top_inst (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .start    (start),
        .t0h      (t0h),
        .t1h      (t1h),
        .tim_sum  (tim_sum),
        .dout     (dout)
    );

    bind ws281x_ctrl ws281x_props ws281x_props_inst (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .rd_en    (rd_en),
        .bit_rdy  (bit_rdy),
        .state    (state)
    );

    always #20 clk_in = ~clk_in;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_color(output color_t c);
        c = '0;
        for (int i = 0; i < COLOR_BITS; i++) begin
            lfsr = lfsr_step(lfsr);
            c = {c[COLOR_BITS-2:0], lfsr[0]};
        end
    endtask

    task automatic check_color(input color_t got, input color_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_width(input tim_t got, input tim_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_idle(input logic got, input string what);
        if (got !== 1'b0) begin
            $display("FAILED at %0t: %s went high, expected it to stay low", $time, what);
            value_errors++;
        end
    endtask

    task automatic write_record(input addr_t addr, input addr_t link, input color_t color);
        @(posedge clk_in);
        #1;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = {2'b00, link, color};
        @(posedge clk_in);
        #1;
        wr_en = 1'b0;
    endtask

    // every slot gets a colour built from its own address.
    task automatic fill_memory();
        addr_t a;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            a = addr_t'(i);
            write_record(a, '0, {a, ~a, a, ~a});
        end
    endtask

    task automatic pulse_start();
        @(posedge clk_in);
        #1;
        start = 1'b1;
        @(posedge clk_in);
        #1;
        start = 1'b0;
    endtask

    task automatic set_timing(input tim_t lo, input tim_t hi, input tim_t sum);
        @(posedge clk_in);
        #1;
        t0h     = lo;
        t1h     = hi;
        tim_sum = sum;
    endtask

    // measures the first rise, each high width and each rise-to-rise period,
    // then watches the line for quiet cycles after the last bit.
    task automatic follow_line(input int nbits, input int quiet);
        int unsigned n;
        int unsigned w;
        widths.delete();
        periods.delete();
        late_high = 1'b0;
        n = 0;
        do begin
            @(negedge clk_in);
            n++;
        end while (!dout && n < WAIT_LIMIT);
        first_rise = n;
        if (!dout) begin
            $display("Timeout: the data line never rose after the start pulse");
            wait_errors++;
            return;
        end
        for (int i = 0; i < nbits; i++) begin
            w = 0;
            do begin
                @(negedge clk_in);
                w++;
            end while (dout && w < WAIT_LIMIT);
            if (dout) begin
                $display("Timeout: the data line stayed high in bit %0d", i);
                wait_errors++;
                return;
            end
            widths.push_back(w);
            if (i < nbits - 1) begin
                n = w;
                do begin
                    @(negedge clk_in);
                    n++;
                end while (!dout && n < WAIT_LIMIT);
                if (!dout) begin
                    $display("Timeout: no rise followed bit %0d of %0d", i, nbits);
                    wait_errors++;
                    return;
                end
                periods.push_back(n);
            end
        end
        for (int q = 0; q < quiet; q++) begin
            @(negedge clk_in);
            late_high = late_high | dout;
        end
    endtask

    task automatic verify_frame(input string name);
        int     nbits;
        int     half;
        int     idx;
        color_t got;
        tim_t   exp_w;
        nbits = exp_colors.size() * COLOR_BITS;
        half  = (int'(t0h) + int'(t1h)) / 2;
        check_width(tim_t'(first_rise), tim_t'(5), {name, ": start to first rise"});
        if (widths.size() != nbits) begin
            $display("FAILED at %0t: %s decoded %0d bits, expected %0d",
                     $time, name, widths.size(), nbits);
            value_errors++;
        end else begin
            for (int r = 0; r < exp_colors.size(); r++) begin
                got = '0;
                for (int b = 0; b < COLOR_BITS; b++) begin
                    idx   = r * COLOR_BITS + b;
                    got   = {got[COLOR_BITS-2:0], int'(widths[idx]) > half};
                    exp_w = exp_colors[r][COLOR_BITS-1-b] ? t1h : t0h;
                    check_width(tim_t'(widths[idx]), exp_w, {name, ": high width"});
                end
                check_color(got, exp_colors[r], {name, ": pixel colour"});
            end
            foreach (periods[i]) begin
                check_width(tim_t'(periods[i]), tim_sum, {name, ": bit period"});
            end
        end
        check_idle(late_high, {name, ": line after the last bit"});
    endtask

    // chain 0 -> 17 -> 5 -> end, with fresh colours.
    task automatic load_chain();
        color_t c0;
        color_t c1;
        color_t c2;
        draw_color(c0);
        draw_color(c1);
        draw_color(c2);
        write_record(6'd0, 6'd17, c0);
        write_record(6'd17, 6'd5, c1);
        write_record(6'd5, 6'd0, c2);
        exp_colors.delete();
        exp_colors.push_back(c0);
        exp_colors.push_back(c1);
        exp_colors.push_back(c2);
    endtask

    task automatic run_chain(input string name);
        load_chain();
        pulse_start();
        follow_line(3 * COLOR_BITS, 2 * int'(tim_sum) + 10);
        verify_frame(name);
    endtask

    task automatic quiet_after_reset();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 100; i++) begin
            @(negedge clk_in);
            seen = seen | dout;
        end
        check_idle(seen, "line without a start pulse");
    endtask

    task automatic single_record_frame();
        color_t c;
        draw_color(c);
        write_record(6'd0, 6'd0, c);
        exp_colors.delete();
        exp_colors.push_back(c);
        pulse_start();
        follow_line(COLOR_BITS, 2 * int'(tim_sum) + 10);
        verify_frame("single record");
    endtask

    task automatic pulse_timing();
        set_timing(8'd3, 8'd7, 8'd12);
        run_chain("short timing");
        set_timing(8'd5, 8'd11, 8'd20);
        run_chain("long timing");
    endtask

    // a second strobe in the middle of a frame must change nothing.
    task automatic ignored_start();
        load_chain();
        pulse_start();
        fork
            follow_line(3 * COLOR_BITS, 2 * int'(tim_sum) + 10);
            begin
                repeat (40) @(posedge clk_in);
                pulse_start();
            end
        join
        verify_frame("start during a frame");
        run_chain("frame after the ignored start");
    endtask

    initial begin
        clk_in       = 1'b0;
        rst_n_in     = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        start        = 1'b0;
        t0h          = 8'd3;
        t1h          = 8'd7;
        tim_sum      = 8'd12;
        value_errors = 0;
        wait_errors  = 0;
        lfsr         = 32'hb38a_fb81;
        repeat (4) @(posedge clk_in);
        #1;
        rst_n_in = 1'b1;

        quiet_after_reset();
        fill_memory();
        single_record_frame();
        run_chain("three record chain");
        pulse_timing();
        ignored_start();

        $display("errors: %0d wrong values, %0d timeouts, %0d assertion failures",
                 value_errors, wait_errors,
                 ws281x_top_inst.ws281x_ctrl_inst.ws281x_props_inst.assert_errors);
        if (value_errors == 0 && wait_errors == 0 &&
            ws281x_top_inst.ws281x_ctrl_inst.ws281x_props_inst.assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
